// ==== Makefile ====
# Verilator build and run of the frame buffer testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module frameBufferTb \
		-Mdir $(OBJ_DIR) -o frameBufferTb

# Passes only when the testbench prints its pass line
run: compile
	@out=$$(./$(OBJ_DIR)/frameBufferTb 2>&1); echo "$$out"; \
		echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/dualPortRam.sv ====
////////////////////////////////////////
// Frame memory, one beat per word
// Write port with a mask per sub-pixel lane
// Read port registered, data one cycle after the address
////////////////////////////////////////
`timescale 1ns/10ps

module dualPortRam
#(
    parameter int PIXELS_PER_BEAT = 2,
    parameter int BEAT_ADDR_WIDTH = 15
)
(
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             write,
    input  logic [BEAT_ADDR_WIDTH-1:0]                       writeAddr,
    input  gpuPixelPkg::pixel_t [PIXELS_PER_BEAT-1:0]        writeData,
    input  gpuPixelPkg::subPixelMask_t [PIXELS_PER_BEAT-1:0] writeMask,
    input  logic [BEAT_ADDR_WIDTH-1:0]                       readAddr,
    output gpuPixelPkg::pixel_t [PIXELS_PER_BEAT-1:0]        readData
);
    import gpuPixelPkg::*;

    // Storage, one entry holds a full beat
    pixel_t [PIXELS_PER_BEAT-1:0] mem [2**BEAT_ADDR_WIDTH];

    // Byte lane writes
    always_ff @(posedge clk)
    begin
        if (write)
        begin
            for (int p = 0; p < PIXELS_PER_BEAT; p++)
            begin
                for (int s = 0; s < SUB_PIXELS; s++)
                begin
                    if (writeMask[p][s])
                    begin
                        mem[writeAddr][p][s] <= writeData[p][s];
                    end
                end
            end
        end
    end

    // Registered read, old data on a same cycle collision
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            readData <= '0;
        end
        else
        begin
            readData <= mem[readAddr];
        end
    end

endmodule

// ==== hw/fbControlPkg.sv ====
////////////////////////////////////////
// Control side definitions of the frame buffer
// Configuration, command states and the scissor test
////////////////////////////////////////
package fbControlPkg;

    import gpuPixelPkg::*;

    // Quasi static configuration, only changed while no command runs
    typedef struct packed {
        pixel_t        clearColor;
        logic          enableScissor;
        screenX_t      scissorStartX;
        screenY_t      scissorStartY;
        screenX_t      scissorEndX;
        screenY_t      scissorEndY;
        screenY_t      yOffset;
        screenX_t      xResolution;
        screenY_t      yResolution;
        subPixelMask_t mask;
    } fbConf_t;

    // Command engine states
    typedef enum logic [1:0] {
        idle,
        commitInit,
        commit,
        memset
    } cmdState_t;

    // Pass when disabled or inside the half open rectangle
    function automatic logic scissorPass(fbConf_t conf, screenX_t x, screenY_t y);
        logic inX;
        logic inY;
        inX = (x >= conf.scissorStartX) && (x < conf.scissorEndX);
        inY = (y >= conf.scissorStartY) && (y < conf.scissorEndY);
        return !conf.enableScissor || (inX && inY);
    endfunction

endpackage

// ==== hw/fragmentPort.sv ====
////////////////////////////////////////
// Single fragment access to the frame memory
// Writes land at the strobe edge with scissor and channel mask
// Reads return two cycles after arvalid
////////////////////////////////////////
`timescale 1ns/10ps

module fragmentPort
#(
    parameter int  PIXELS_PER_BEAT = 2,
    parameter int  ADDR_WIDTH      = 16,
    parameter type MEM_BUS_T       = logic
)
(
    input  logic                                      clk,
    input  logic                                      reset,
    input  fbControlPkg::fbConf_t                     conf,
    input  logic                                      wvalid,
    input  gpuPixelPkg::fragWrite_t                   wfrag,
    input  logic                                      arvalid,
    input  gpuPixelPkg::fragRead_t                    arfrag,
    input  gpuPixelPkg::pixel_t [PIXELS_PER_BEAT-1:0] ramReadData,
    output MEM_BUS_T                                  fragBus,
    output logic                                      rvalid,
    output logic                                      rlast,
    output gpuPixelPkg::pixel_t                       rdata
);
    import gpuPixelPkg::*;
    import fbControlPkg::*;

    localparam int LANE_BITS       = $clog2(PIXELS_PER_BEAT);
    localparam int LANE_WIDTH      = (LANE_BITS == 0) ? 1 : LANE_BITS;
    localparam int BEAT_ADDR_WIDTH = ADDR_WIDTH - LANE_BITS;

    // Pixel position inside a beat
    typedef logic [LANE_WIDTH-1:0] lane_t;

    // Read request travelling beside the RAM latency
    typedef struct packed {
        logic  valid;
        logic  last;
        lane_t lane;
    } readTag_t;

    lane_t         writeLane;
    lane_t         readLane;
    subPixelMask_t writeChannels;
    readTag_t      readTag;

    // Low address bits pick the lane, always zero for one pixel per beat
    assign writeLane = lane_t'(wfrag.addr) & lane_t'(PIXELS_PER_BEAT - 1);
    assign readLane  = lane_t'(arfrag.addr) & lane_t'(PIXELS_PER_BEAT - 1);

    ////////////////////////////////////////
    // Memory request
    ////////////////////////////////////////
    always_comb
    begin
        // A failed scissor test drops every channel
        writeChannels = scissorPass(conf, wfrag.screenX, wfrag.screenY)
                      ? (wfrag.strb & conf.mask) : '0;

        fragBus.write     = wvalid;
        fragBus.writeAddr = wfrag.addr[LANE_BITS +: BEAT_ADDR_WIDTH];
        // Pixel copied into every lane, the mask picks the one written
        fragBus.writeData = {PIXELS_PER_BEAT{wfrag.data}};
        for (int p = 0; p < PIXELS_PER_BEAT; p++)
        begin
            fragBus.writeMask[p] = (writeLane == lane_t'(p)) ? writeChannels : '0;
        end
        fragBus.readAddr  = arfrag.addr[LANE_BITS +: BEAT_ADDR_WIDTH];
    end

    ////////////////////////////////////////
    // Read return
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        // Stage one runs beside the RAM read register
        readTag <= '{valid: arvalid, last: arfrag.last, lane: readLane};

        // Stage two picks the pixel out of the beat
        rdata <= ramReadData[readTag.lane];
        rlast <= readTag.last;

        if (reset)
        begin
            readTag.valid <= 1'b0;
            rvalid        <= 1'b0;
        end
        else
        begin
            rvalid <= readTag.valid;
        end
    end

endmodule

// ==== hw/frameBuffer.sv ====
////////////////////////////////////////
// Frame buffer of the pixel back end
// Fragment reads and writes when idle, commit and memset on apply
// Commit streams the frame one beat at a time with back-pressure
////////////////////////////////////////
`timescale 1ns/10ps

module frameBuffer
#(
    parameter int PIXELS_PER_BEAT = 2,
    parameter int ADDR_WIDTH      = 16
)
(
    input  logic                                      clk,
    input  logic                                      reset,
    input  fbControlPkg::fbConf_t                     conf,
    // Commands
    input  logic                                      apply,
    input  logic                                      cmdCommit,
    input  logic                                      cmdMemset,
    output logic                                      applied,
    // Fragment access
    input  logic                                      wvalid,
    input  gpuPixelPkg::fragWrite_t                   wfrag,
    input  logic                                      arvalid,
    input  gpuPixelPkg::fragRead_t                    arfrag,
    output logic                                      rvalid,
    output logic                                      rlast,
    output gpuPixelPkg::pixel_t                       rdata,
    // Frame stream
    output logic                                      streamValid,
    input  logic                                      streamReady,
    output logic                                      streamLast,
    output gpuPixelPkg::pixel_t [PIXELS_PER_BEAT-1:0] streamData
);
    import gpuPixelPkg::*;

    localparam int LANE_BITS       = $clog2(PIXELS_PER_BEAT);
    localparam int BEAT_ADDR_WIDTH = ADDR_WIDTH - LANE_BITS;

    typedef logic [BEAT_ADDR_WIDTH-1:0]           beatAddr_t;
    typedef pixel_t [PIXELS_PER_BEAT-1:0]         beat_t;
    typedef subPixelMask_t [PIXELS_PER_BEAT-1:0]  beatMask_t;

    // Frame memory request, one per owner
    typedef struct packed {
        logic      write;
        beatAddr_t writeAddr;
        beat_t     writeData;
        beatMask_t writeMask;
        beatAddr_t readAddr;
    } memBus_t;

    memBus_t fragBus;
    memBus_t cmdBus;
    memBus_t memBus;
    beat_t   ramReadData;
    logic    busy;

    // Command engine owns the memory while it runs
    assign memBus = busy ? cmdBus : fragBus;

    dualPortRam #(
        .PIXELS_PER_BEAT(PIXELS_PER_BEAT),
        .BEAT_ADDR_WIDTH(BEAT_ADDR_WIDTH)
    ) i_ram (
        .clk      (clk),
        .reset    (reset),
        .write    (memBus.write),
        .writeAddr(memBus.writeAddr),
        .writeData(memBus.writeData),
        .writeMask(memBus.writeMask),
        .readAddr (memBus.readAddr),
        .readData (ramReadData)
    );

    fragmentPort #(
        .PIXELS_PER_BEAT(PIXELS_PER_BEAT),
        .ADDR_WIDTH     (ADDR_WIDTH),
        .MEM_BUS_T      (memBus_t)
    ) i_fragmentPort (
        .clk        (clk),
        .reset      (reset),
        .conf       (conf),
        .wvalid     (wvalid),
        .wfrag      (wfrag),
        .arvalid    (arvalid),
        .arfrag     (arfrag),
        .ramReadData(ramReadData),
        .fragBus    (fragBus),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .rdata      (rdata)
    );

    frameCommandEngine #(
        .PIXELS_PER_BEAT(PIXELS_PER_BEAT),
        .ADDR_WIDTH     (ADDR_WIDTH),
        .MEM_BUS_T      (memBus_t)
    ) i_commandEngine (
        .clk        (clk),
        .reset      (reset),
        .conf       (conf),
        .apply      (apply),
        .cmdCommit  (cmdCommit),
        .cmdMemset  (cmdMemset),
        .streamReady(streamReady),
        .applied    (applied),
        .busy       (busy),
        .cmdBus     (cmdBus),
        .streamValid(streamValid),
        .streamLast (streamLast)
    );

    // Registered RAM output is the current stream beat
    assign streamData = ramReadData;

endmodule

// ==== hw/frameCommandEngine.sv ====
////////////////////////////////////////
// Commit and memset sequencer of the frame buffer
// Owns the frame memory while busy is high
// Commands start on apply in idle, applied is low while running
////////////////////////////////////////
`timescale 1ns/10ps

module frameCommandEngine
#(
    parameter int  PIXELS_PER_BEAT = 2,
    parameter int  ADDR_WIDTH      = 16,
    parameter type MEM_BUS_T       = logic
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  fbControlPkg::fbConf_t conf,
    input  logic                  apply,
    input  logic                  cmdCommit,
    input  logic                  cmdMemset,
    input  logic                  streamReady,
    output logic                  applied,
    output logic                  busy,
    output MEM_BUS_T              cmdBus,
    output logic                  streamValid,
    output logic                  streamLast
);
    import gpuPixelPkg::*;
    import fbControlPkg::*;

    localparam int LANE_BITS       = $clog2(PIXELS_PER_BEAT);
    localparam int BEAT_ADDR_WIDTH = ADDR_WIDTH - LANE_BITS;

    // One bit wider than a beat address so a full memory fits
    typedef logic [BEAT_ADDR_WIDTH:0] beatCount_t;
    // Product of both resolutions
    typedef logic [2*SCREEN_WIDTH-1:0] pixelCount_t;

    cmdState_t                  state;
    beatCount_t                 index;
    beatCount_t                 indexNext;
    beatCount_t                 fbSizeInBeats;
    pixelCount_t                pixelCount;
    logic                       memsetPending;
    screenX_t                   memsetX;
    screenX_t                   memsetXNext;
    screenY_t                   memsetY;
    logic [PIXELS_PER_BEAT-1:0] scissorOk;

    assign indexNext   = index + beatCount_t'(1);
    assign memsetXNext = memsetX + screenX_t'(PIXELS_PER_BEAT);
    assign pixelCount  = conf.xResolution * conf.yResolution;

    ////////////////////////////////////////
    // Memory request
    ////////////////////////////////////////
    always_comb
    begin
        // Scissor per pixel of the current memset beat
        for (int p = 0; p < PIXELS_PER_BEAT; p++)
        begin
            scissorOk[p] = scissorPass(conf, memsetX + screenX_t'(p), memsetY);
        end

        cmdBus.write     = (state == memset);
        cmdBus.writeAddr = index[BEAT_ADDR_WIDTH-1:0];
        cmdBus.writeData = {PIXELS_PER_BEAT{conf.clearColor}};
        for (int p = 0; p < PIXELS_PER_BEAT; p++)
        begin
            cmdBus.writeMask[p] = scissorOk[p] ? conf.mask : '0;
        end

        // Run ahead on an accepted beat so the RAM output shows the next one
        if ((state == commit) && streamReady)
        begin
            cmdBus.readAddr = indexNext[BEAT_ADDR_WIDTH-1:0];
        end
        else
        begin
            cmdBus.readAddr = index[BEAT_ADDR_WIDTH-1:0];
        end
    end

    ////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state         <= idle;
            busy          <= 1'b0;
            applied       <= 1'b1;
            memsetPending <= 1'b0;
            streamValid   <= 1'b0;
            streamLast    <= 1'b0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    // Counters reload while waiting
                    index         <= '0;
                    fbSizeInBeats <= beatCount_t'(pixelCount >> LANE_BITS);
                    memsetX       <= '0;
                    // Memory starts at the top row, screen Y counts upward
                    memsetY       <= conf.yOffset + conf.yResolution - screenY_t'(1);

                    if (apply)
                    begin
                        applied       <= 1'b0;
                        busy          <= 1'b1;
                        memsetPending <= cmdMemset;
                        // Commit wins, memset follows it
                        if (cmdCommit)
                        begin
                            state <= commitInit;
                        end
                        else if (cmdMemset)
                        begin
                            state <= memset;
                        end
                    end
                    else
                    begin
                        applied <= 1'b1;
                        busy    <= 1'b0;
                    end
                end

                commitInit:
                begin
                    // Beat 0 is on the RAM output from the next cycle
                    streamValid <= 1'b1;
                    streamLast  <= (fbSizeInBeats == beatCount_t'(1));
                    state       <= commit;
                end

                commit:
                begin
                    if (streamReady)
                    begin
                        index <= indexNext;
                        if (indexNext == fbSizeInBeats - beatCount_t'(1))
                        begin
                            streamLast <= 1'b1;
                        end
                        // Final beat accepted
                        if (indexNext == fbSizeInBeats)
                        begin
                            streamValid <= 1'b0;
                            streamLast  <= 1'b0;
                            index       <= '0;
                            state       <= memsetPending ? memset : idle;
                        end
                    end
                end

                memset:
                begin
                    index <= indexNext;
                    if (indexNext == fbSizeInBeats)
                    begin
                        state <= idle;
                    end
                    // Row wrap
                    if (memsetXNext == conf.xResolution)
                    begin
                        memsetX <= '0;
                        memsetY <= memsetY - screenY_t'(1);
                    end
                    else
                    begin
                        memsetX <= memsetXNext;
                    end
                end

                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// ==== hw/gpuPixelPkg.sv ====
////////////////////////////////////////
// Pixel, screen and fragment types of the pixel back end
// Import wherever pixel data, screen positions or fragments are handled
////////////////////////////////////////
package gpuPixelPkg;

    // Colour channels per pixel and bits per channel
    localparam int SUB_PIXELS = 4;
    localparam int SUB_PIXEL_WIDTH = 8;

    // Screen coordinate range and fragment address range
    localparam int SCREEN_WIDTH = 11;
    localparam int FRAG_ADDR_WIDTH = 16;

    // One enable bit per colour channel
    typedef logic [SUB_PIXELS-1:0] subPixelMask_t;

    // Channel 0 sits in the low byte
    typedef logic [SUB_PIXELS-1:0][SUB_PIXEL_WIDTH-1:0] pixel_t;

    typedef logic [SCREEN_WIDTH-1:0] screenX_t;
    typedef logic [SCREEN_WIDTH-1:0] screenY_t;

    // Pixel index into the frame buffer
    typedef logic [FRAG_ADDR_WIDTH-1:0] fragAddr_t;

    // Single fragment write, screen position is only used for the scissor
    typedef struct packed {
        fragAddr_t     addr;
        pixel_t        data;
        subPixelMask_t strb;
        screenX_t      screenX;
        screenY_t      screenY;
    } fragWrite_t;

    // Single fragment read, last is echoed back with the data
    typedef struct packed {
        fragAddr_t addr;
        logic      last;
    } fragRead_t;

endpackage

// ==== sim/frameBufferTb.sv ====
////////////////////////////////////////
// Testbench of the frame buffer
// Random fragment traffic, scissor, memset and commit against a shadow memory
// Run with the DUT at two pixels per beat and a 256 pixel memory
////////////////////////////////////////
`timescale 1ns/10ps

module frameBufferTb;
    import gpuPixelPkg::*;
    import fbControlPkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int PIXELS         = 256;
    localparam int SCREEN_W       = 16;
    localparam int SCREEN_H       = 8;
    localparam int FRAME_BEATS    = SCREEN_W * SCREEN_H / 2;
    localparam int RW_CYCLES      = 400;
    localparam int SCISSOR_CYCLES = 300;
    // Nominal cycles of all tests summed in test order
    localparam int TEST_CYCLES = 5 + (PIXELS + 4) + (RW_CYCLES + 4)
                               + (SCISSOR_CYCLES + PIXELS + 8)
                               + (FRAME_BEATS + PIXELS + 16)
                               + (2 * FRAME_BEATS + 16)
                               + (3 * FRAME_BEATS + PIXELS + 24);

    logic         clk = 1'b0;
    logic         reset;
    fbConf_t      conf;
    logic         apply;
    logic         cmdCommit;
    logic         cmdMemset;
    logic         applied;
    logic         wvalid;
    fragWrite_t   wfrag;
    logic         arvalid;
    fragRead_t    arfrag;
    logic         rvalid;
    logic         rlast;
    pixel_t       rdata;
    logic         streamValid;
    logic         streamReady;
    logic         streamLast;
    pixel_t [1:0] streamData;

    // Shadow memory and two stages of reads in flight
    pixel_t shadow [PIXELS];
    logic   pendValid [2];
    logic   pendLast [2];
    pixel_t pendData [2];
    string  testName;

    frameBuffer #(
        .PIXELS_PER_BEAT(2),
        .ADDR_WIDTH     (8)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .conf       (conf),
        .apply      (apply),
        .cmdCommit  (cmdCommit),
        .cmdMemset  (cmdMemset),
        .applied    (applied),
        .wvalid     (wvalid),
        .wfrag      (wfrag),
        .arvalid    (arvalid),
        .arfrag     (arfrag),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .rdata      (rdata),
        .streamValid(streamValid),
        .streamReady(streamReady),
        .streamLast (streamLast),
        .streamData (streamData)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Checks and model
    ////////////////////////////////////////
    task automatic checkValue(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (actual === expected)
        else
        begin
            $display("MISMATCH %s: %s expected %h actual %h", testName, what, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Half open rectangle that passes everything with the scissor off
    function automatic logic insideScissor(input screenX_t x, input screenY_t y);
        if (!conf.enableScissor)
        begin
            return 1'b1;
        end
        return (x >= conf.scissorStartX) && (x < conf.scissorEndX)
            && (y >= conf.scissorStartY) && (y < conf.scissorEndY);
    endfunction

    // Channel written only if strobe and mask agree and the scissor passes
    function automatic void modelWrite(input int addr, input pixel_t data,
                                       input subPixelMask_t strb,
                                       input screenX_t x, input screenY_t y);
        if (insideScissor(x, y))
        begin
            for (int s = 0; s < SUB_PIXELS; s++)
            begin
                if (strb[s] && conf.mask[s])
                begin
                    shadow[addr][s] = data[s];
                end
            end
        end
    endfunction

    // Memory index 0 is the top left corner where screen Y is highest
    function automatic void memsetModel();
        screenX_t x;
        screenY_t y;
        for (int i = 0; i < SCREEN_W * SCREEN_H; i++)
        begin
            x = screenX_t'(i % SCREEN_W);
            y = screenY_t'(SCREEN_H - 1 - i / SCREEN_W);
            modelWrite(i, conf.clearColor, 4'hF, x, y);
        end
    endfunction

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////
    // Step to the next falling edge and check what the read pipe returns
    task automatic nextCycle();
        @(negedge clk);
        checkValue("rvalid", 64'(pendValid[1]), 64'(rvalid));
        if (pendValid[1])
        begin
            checkValue("rdata", 64'(pendData[1]), 64'(rdata));
            checkValue("rlast", 64'(pendLast[1]), 64'(rlast));
        end
        pendValid[1] = pendValid[0];
        pendData[1]  = pendData[0];
        pendLast[1]  = pendLast[0];
        pendValid[0] = 1'b0;
        wvalid       = 1'b0;
        arvalid      = 1'b0;
    endtask

    // Expected data is taken before any write of the same cycle
    task automatic issueRead(input int addr, input logic last);
        arvalid      = 1'b1;
        arfrag.addr  = 16'(addr);
        arfrag.last  = last;
        pendValid[0] = 1'b1;
        pendData[0]  = shadow[addr];
        pendLast[0]  = last;
    endtask

    task automatic issueWrite(input int addr, input pixel_t data, input subPixelMask_t strb,
                              input screenX_t x, input screenY_t y);
        wvalid        = 1'b1;
        wfrag.addr    = 16'(addr);
        wfrag.data    = data;
        wfrag.strb    = strb;
        wfrag.screenX = x;
        wfrag.screenY = y;
        modelWrite(addr, data, strb, x, y);
    endtask

    task automatic readAll();
        for (int i = 0; i < PIXELS; i++)
        begin
            issueRead(i, 1'($urandom));
            nextCycle();
        end
        nextCycle();
        nextCycle();
    endtask

    task automatic randomScissor();
        conf.enableScissor = 1'b1;
        conf.scissorStartX = screenX_t'($urandom % 10);
        conf.scissorEndX   = conf.scissorStartX + screenX_t'(2 + $urandom % 6);
        conf.scissorStartY = screenY_t'($urandom % 5);
        conf.scissorEndY   = conf.scissorStartY + screenY_t'(1 + $urandom % 4);
    endtask

    // Level handshake with stream beats checked as they are accepted
    task automatic runCommand(input logic doCommit, input logic doMemset);
        int beats;
        beats     = 0;
        apply     = 1'b1;
        cmdCommit = doCommit;
        cmdMemset = doMemset;
        do
        begin
            // Transfer happens at the coming rising edge
            streamReady = doCommit ? 1'($urandom) : 1'b0;
            if (!doCommit)
            begin
                checkValue("idle streamValid", 64'd0, 64'(streamValid));
            end
            if (streamValid && streamReady)
            begin
                checkValue("stream beat", {shadow[2 * beats + 1], shadow[2 * beats]},
                           64'(streamData));
                checkValue("streamLast", 64'(beats == FRAME_BEATS - 1), 64'(streamLast));
                beats++;
            end
            nextCycle();
            if (!applied)
            begin
                apply = 1'b0;
            end
        end
        while (apply || !applied);
        streamReady = 1'b0;
        cmdCommit   = 1'b0;
        cmdMemset   = 1'b0;
        if (doCommit)
        begin
            checkValue("beat count", 64'(FRAME_BEATS), 64'(beats));
        end
        if (doMemset)
        begin
            memsetModel();
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial
    begin
        void'($urandom(32'h4ab4d7a4));
        reset       = 1'b1;
        conf        = '0;
        conf.xResolution = screenX_t'(SCREEN_W);
        conf.yResolution = screenY_t'(SCREEN_H);
        conf.mask   = 4'hF;
        apply       = 1'b0;
        cmdCommit   = 1'b0;
        cmdMemset   = 1'b0;
        wvalid      = 1'b0;
        wfrag       = '0;
        arvalid     = 1'b0;
        arfrag      = '0;
        streamReady = 1'b0;
        for (int i = 0; i < 2; i++)
        begin
            pendValid[i] = 1'b0;
            pendData[i]  = '0;
            pendLast[i]  = 1'b0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        testName = "reset";
        checkValue("applied", 64'd1, 64'(applied));
        checkValue("streamValid", 64'd0, 64'(streamValid));
        checkValue("rvalid", 64'd0, 64'(rvalid));

        // Known contents in every pixel
        testName = "init";
        for (int i = 0; i < PIXELS; i++)
        begin
            issueWrite(i, 32'($urandom), 4'hF, 11'd0, 11'd0);
            nextCycle();
        end

        testName = "fragment";
        conf.mask = 4'($urandom);
        for (int n = 0; n < RW_CYCLES; n++)
        begin
            if ($urandom % 2 == 0)
            begin
                issueRead(int'($urandom % PIXELS), 1'($urandom));
            end
            if ($urandom % 2 == 0)
            begin
                issueWrite(int'($urandom % PIXELS), 32'($urandom), 4'($urandom),
                           11'($urandom), 11'($urandom));
            end
            nextCycle();
        end
        nextCycle();
        nextCycle();

        testName = "scissor";
        conf.mask = 4'($urandom);
        randomScissor();
        for (int n = 0; n < SCISSOR_CYCLES; n++)
        begin
            issueWrite(int'($urandom % PIXELS), 32'($urandom), 4'($urandom),
                       11'($urandom % 20), 11'($urandom % 10));
            nextCycle();
        end
        readAll();

        testName = "memset";
        conf.clearColor = 32'($urandom);
        conf.mask       = 4'($urandom);
        randomScissor();
        runCommand(1'b0, 1'b1);
        readAll();

        testName = "commit";
        runCommand(1'b1, 1'b0);

        testName = "commit and memset";
        conf.clearColor = 32'($urandom);
        conf.mask       = 4'($urandom);
        randomScissor();
        runCommand(1'b1, 1'b1);
        readAll();

        $display("test passed");
        $finish;
    end

    // Watchdog on four times the nominal run length
    initial
    begin
        #(TEST_CYCLES * 4 * CLK_PERIOD);
        $display("Watchdog expired, the DUT stopped responding");
        $display("test failed");
        $fatal(1);
    end

endmodule

// ==== vlog.f ====
hw/gpuPixelPkg.sv
hw/fbControlPkg.sv
hw/dualPortRam.sv
hw/fragmentPort.sv
hw/frameCommandEngine.sv
hw/frameBuffer.sv
sim/frameBufferTb.sv
